// File: include/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// pc and target width
`define BP_XLEN 32

// table geometry, index is pc[9:2]
`define BP_INDEX_BITS 8
`define BP_ENTRIES 256

// rv32i conditional branch opcode
`define BP_OP_WIDTH 7
`define BP_OP_BRANCH 7'b1100011

`endif

// File: verilog/bp_pkg.sv
`include "bp_defines.svh"

package bp_pkg;

  // 2-bit saturating counter, upper half predicts taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } counter_t;

  typedef logic [`BP_XLEN-1:0] pc_t; // pcs and branch targets

endpackage

// File: verilog/bp_table.sv
`timescale 1ns/100ps
`include "bp_defines.svh"

module bp_table #(
  parameter type payload_t = logic [1:0],
  parameter payload_t reset_value = '0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`BP_INDEX_BITS-1:0] rd_index_a,
  output payload_t                  rd_data_a,
  input  logic [`BP_INDEX_BITS-1:0] rd_index_b,
  output payload_t                  rd_data_b,
  input  logic                      we,
  input  logic [`BP_INDEX_BITS-1:0] wr_index,
  input  payload_t                  wr_data
);

  payload_t entries [`BP_ENTRIES];

  // async reads, old data returned during a same-cycle write
  assign rd_data_a = entries[rd_index_a];
  assign rd_data_b = entries[rd_index_b];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        entries[i] <= reset_value;
      end
    end else if (we) begin
      entries[wr_index] <= wr_data;
    end
  end

  // execute stage must present a clean index with every write
  a_wr_index_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    we |-> !$isunknown(wr_index)
  ) else $error("bp_table write with unknown index");

endmodule

// File: verilog/bp_decode.sv
`timescale 1ns/100ps
`include "bp_defines.svh"

module bp_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  bp_pkg::pc_t               pc_d,
  input  logic [`BP_OP_WIDTH-1:0]   opcode_d,
  output logic [`BP_INDEX_BITS-1:0] rd_index_d,
  input  bp_pkg::counter_t          counter_d,
  input  bp_pkg::pc_t               target_d,
  input  logic                      redirect,
  output logic                      predict_taken,
  output bp_pkg::pc_t               predict_pc,
  output logic                      pred_taken_e,
  output bp_pkg::pc_t               pred_pc_e
);

  import bp_pkg::*;

  logic is_branch_d;
  logic counter_taken;
  pc_t  fallthrough_pc;

  assign rd_index_d = pc_d[`BP_INDEX_BITS+1:2]; // word aligned, no tag

  assign is_branch_d    = (opcode_d == `BP_OP_BRANCH);
  assign counter_taken  = (counter_d == weak_t) || (counter_d == strong_t);
  assign fallthrough_pc = pc_d + `BP_XLEN'd4;

  // only conditional branches may be predicted taken
  assign predict_taken = is_branch_d && counter_taken;
  assign predict_pc    = predict_taken ? target_d : fallthrough_pc;

  // prediction follows the instruction from D into E
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred_taken_e <= 1'b0;
    end else if (redirect) begin
      pred_taken_e <= 1'b0; // squashed slot carries no prediction
    end else begin
      pred_taken_e <= predict_taken;
    end
  end

  always_ff @(posedge clk) begin
    if (redirect) begin
      pred_pc_e <= fallthrough_pc;
    end else begin
      pred_pc_e <= predict_pc;
    end
  end

  // tables are cleared by reset, so a lookup never sees unknown data
  a_prediction_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown({predict_taken, predict_pc})
  ) else $error("unknown prediction in decode");

endmodule

// File: verilog/bp_execute.sv
`timescale 1ns/100ps
`include "bp_defines.svh"

module bp_execute (
  input  logic                      clk,
  input  logic                      rst_n,
  input  bp_pkg::pc_t               pc_e,
  input  logic                      branch_e,
  input  logic                      taken_e,
  input  bp_pkg::pc_t               target_e,
  output logic [`BP_INDEX_BITS-1:0] rd_index_e,
  input  bp_pkg::counter_t          counter_e,
  output logic                      cnt_we,
  output logic                      tgt_we,
  output logic [`BP_INDEX_BITS-1:0] wr_index,
  output bp_pkg::counter_t          cnt_wdata,
  output bp_pkg::pc_t               tgt_wdata
);

  import bp_pkg::*;

  counter_t counter_next;

  assign rd_index_e = pc_e[`BP_INDEX_BITS+1:2];

  // one step toward the outcome, saturating at both ends
  always_comb begin
    case (counter_e)
      strong_nt: counter_next = taken_e ? weak_nt  : strong_nt;
      weak_nt:   counter_next = taken_e ? weak_t   : strong_nt;
      weak_t:    counter_next = taken_e ? strong_t : weak_nt;
      strong_t:  counter_next = taken_e ? strong_t : weak_t;
      default:   counter_next = strong_nt;
    endcase
  end

  // written at the edge that ends the execute cycle
  assign cnt_we    = branch_e;
  assign tgt_we    = branch_e && taken_e; // target only known useful when taken
  assign wr_index  = rd_index_e;
  assign cnt_wdata = counter_next;
  assign tgt_wdata = target_e;

  // a resolved branch must bring a clean pc, outcome and target
  a_branch_inputs_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    branch_e |-> !$isunknown({pc_e, taken_e, target_e})
  ) else $error("resolved branch with unknown pc, outcome or target");

endmodule

// File: verilog/bp_result.sv
`timescale 1ns/100ps
`include "bp_defines.svh"

module bp_result (
  input  bp_pkg::pc_t pc_e,
  input  logic        branch_e,
  input  logic        taken_e,
  input  bp_pkg::pc_t target_e,
  input  logic        pred_taken_e,
  input  bp_pkg::pc_t pred_pc_e,
  output logic        flush_d,
  output logic        flush_e,
  output logic        redirect,
  output bp_pkg::pc_t redirect_pc
);

  import bp_pkg::*;

  logic actual_taken;
  logic bad_non_branch;
  logic bad_direction;
  logic bad_target;
  logic mispredict;
  pc_t  fallthrough_pc;

  assign actual_taken   = branch_e && taken_e;
  assign fallthrough_pc = pc_e + `BP_XLEN'd4;

  // predicted taken but execute holds no branch
  assign bad_non_branch = pred_taken_e && !branch_e;
  assign bad_direction  = branch_e && (taken_e != pred_taken_e);
  // right direction, stale or aliased target
  assign bad_target     = actual_taken && (target_e != pred_pc_e);

  assign mispredict = bad_non_branch || bad_direction || bad_target;

  // D and E both hold wrong-path work on a mispredict
  assign redirect    = mispredict;
  assign flush_d     = mispredict;
  assign flush_e     = mispredict;
  assign redirect_pc = actual_taken ? target_e : fallthrough_pc;

endmodule

// File: verilog/branch_predictor_top.sv
`timescale 1ns/100ps
`include "bp_defines.svh"

module branch_predictor_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  bp_pkg::pc_t             pc_d,
  input  logic [`BP_OP_WIDTH-1:0] opcode_d,
  input  bp_pkg::pc_t             pc_e,
  input  logic                    branch_e,
  input  logic                    taken_e,
  input  bp_pkg::pc_t             target_e,
  output logic                    predict_taken,
  output bp_pkg::pc_t             predict_pc,
  output logic                    flush_d,
  output logic                    flush_e,
  output logic                    redirect,
  output bp_pkg::pc_t             redirect_pc
);

  import bp_pkg::*;

  logic [`BP_INDEX_BITS-1:0] rd_index_d;
  logic [`BP_INDEX_BITS-1:0] rd_index_e;
  logic [`BP_INDEX_BITS-1:0] wr_index;
  counter_t                  counter_d;
  counter_t                  counter_e;
  counter_t                  cnt_wdata;
  pc_t                       target_d;
  pc_t                       tgt_wdata;
  logic                      cnt_we;
  logic                      tgt_we;
  logic                      pred_taken_e;
  pc_t                       pred_pc_e;

  bp_table #(
    .payload_t   (counter_t),
    .reset_value (strong_nt)
  ) counter_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_index_a (rd_index_d),
    .rd_data_a  (counter_d),
    .rd_index_b (rd_index_e),
    .rd_data_b  (counter_e),
    .we         (cnt_we),
    .wr_index   (wr_index),
    .wr_data    (cnt_wdata)
  );

  // port b not needed, execute never reads targets
  bp_table #(
    .payload_t   (pc_t),
    .reset_value ('0)
  ) target_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_index_a (rd_index_d),
    .rd_data_a  (target_d),
    .rd_index_b ('0),
    .rd_data_b  (),
    .we         (tgt_we),
    .wr_index   (wr_index),
    .wr_data    (tgt_wdata)
  );

  bp_decode i_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_d          (pc_d),
    .opcode_d      (opcode_d),
    .rd_index_d    (rd_index_d),
    .counter_d     (counter_d),
    .target_d      (target_d),
    .redirect      (redirect),
    .predict_taken (predict_taken),
    .predict_pc    (predict_pc),
    .pred_taken_e  (pred_taken_e),
    .pred_pc_e     (pred_pc_e)
  );

  bp_execute i_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_e       (pc_e),
    .branch_e   (branch_e),
    .taken_e    (taken_e),
    .target_e   (target_e),
    .rd_index_e (rd_index_e),
    .counter_e  (counter_e),
    .cnt_we     (cnt_we),
    .tgt_we     (tgt_we),
    .wr_index   (wr_index),
    .cnt_wdata  (cnt_wdata),
    .tgt_wdata  (tgt_wdata)
  );

  bp_result i_result (
    .pc_e         (pc_e),
    .branch_e     (branch_e),
    .taken_e      (taken_e),
    .target_e     (target_e),
    .pred_taken_e (pred_taken_e),
    .pred_pc_e    (pred_pc_e),
    .flush_d      (flush_d),
    .flush_e      (flush_e),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc)
  );

endmodule

// File: sim/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

logic [1:0]  m_counter [`BP_ENTRIES]; // 0 strong_nt .. 3 strong_t
logic [31:0] m_target  [`BP_ENTRIES];
logic        m_pred_taken; // prediction held for the execute stage
logic [31:0] m_pred_pc;

task automatic model_reset();
  for (int i = 0; i < `BP_ENTRIES; i++) begin
    m_counter[i] = 2'd0;
    m_target[i]  = 32'd0;
  end
  m_pred_taken = 1'b0;
  m_pred_pc    = 32'd4; // pc_d sits at zero during reset
endtask

function automatic logic [7:0] index_of(input logic [31:0] pc);
  return pc[9:2];
endfunction

// saturating step toward the outcome
function automatic logic [1:0] train(input logic [1:0] c, input logic taken);
  if (taken) begin
    return (c == 2'd3) ? c : c + 2'd1;
  end
  return (c == 2'd0) ? c : c - 2'd1;
endfunction

function automatic logic model_taken(input logic [31:0] pc, input logic [6:0] op);
  return (op == `BP_OP_BRANCH) && (m_counter[index_of(pc)] >= 2'd2);
endfunction

function automatic logic [31:0] model_pc(input logic [31:0] pc, input logic [6:0] op);
  return model_taken(pc, op) ? m_target[index_of(pc)] : pc + 32'd4;
endfunction

function automatic logic model_mispredict(input logic branch, input logic taken,
                                          input logic [31:0] target);
  if (m_pred_taken && !branch) begin
    return 1'b1;
  end
  if (branch && (taken != m_pred_taken)) begin
    return 1'b1;
  end
  return branch && taken && (target != m_pred_pc); // stale target
endfunction

// one rising edge: tables train, then the D/E register loads
task automatic model_clock(input logic [31:0] pc_d_in, input logic [6:0] op,
                           input logic [31:0] pc_e_in, input logic branch,
                           input logic taken, input logic [31:0] target,
                           input logic flush);
  logic        next_taken;
  logic [31:0] next_pc;
  next_taken = model_taken(pc_d_in, op); // old table contents
  next_pc    = model_pc(pc_d_in, op);
  if (branch) begin
    m_counter[index_of(pc_e_in)] = train(m_counter[index_of(pc_e_in)], taken);
    if (taken) begin
      m_target[index_of(pc_e_in)] = target;
    end
  end
  if (flush) begin
    m_pred_taken = 1'b0;
    m_pred_pc    = pc_d_in + 32'd4;
  end else begin
    m_pred_taken = next_taken;
    m_pred_pc    = next_pc;
  end
endtask

`endif

// File: sim/tb_branch_predictor.sv
`timescale 1ns/100ps
`include "bp_defines.svh"

module tb_branch_predictor;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 16;
  localparam int LOOKUP_CYCLES = 8;
  localparam int RUN_CYCLES    = 4000;
  localparam int CYCLE_LIMIT   = RESET_CYCLES + LOOKUP_CYCLES + RUN_CYCLES + 50;

  logic        clk;
  logic        rst_n;
  logic [31:0] pc_d;
  logic [6:0]  opcode_d;
  logic [31:0] pc_e;
  logic        branch_e;
  logic        taken_e;
  logic [31:0] target_e;
  logic        predict_taken;
  logic [31:0] predict_pc;
  logic        flush_d;
  logic        flush_e;
  logic        redirect;
  logic [31:0] redirect_pc;

  logic [31:0] lfsr_state;
  logic [31:0] pc_pool [16];
  logic [31:0] target_pool [16]; // resolved target per pool entry
  logic [3:0]  prev_sel;
  logic        prev_branch;
  logic        prev_flushed;
  int          cycle_count;
  string       test_name;

  `include "bp_ref_model.svh"

  branch_predictor_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_d          (pc_d),
    .opcode_d      (opcode_d),
    .pc_e          (pc_e),
    .branch_e      (branch_e),
    .taken_e       (taken_e),
    .target_e      (target_e),
    .predict_taken (predict_taken),
    .predict_pc    (predict_pc),
    .flush_d       (flush_d),
    .flush_e       (flush_e),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Finished with errors");
    $fatal(1, "timeout");
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic compare_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error: test %s, %s expected %h actual %h", test_name, field, expected, actual);
      $display("Finished with errors");
      $fatal(1, "mismatch");
    end
  endtask

  // four aliasing pairs share pc[9:2] with their neighbour
  task automatic build_pools();
    logic [31:0] r;
    for (int i = 0; i < 16; i++) begin
      draw_bits(30, r);
      if (i % 4 == 1) begin
        pc_pool[i] = pc_pool[i - 1] ^ 32'h0000_5c00;
      end else begin
        pc_pool[i] = {r[29:0], 2'b00};
      end
      draw_bits(30, r);
      target_pool[i] = {r[29:0], 2'b00};
    end
  endtask

  task automatic run_cycle(input logic lookup_only);
    logic [31:0] r;
    logic [3:0]  sel;
    logic        is_branch;
    logic        exp_taken;
    logic [31:0] exp_pc;
    logic        exp_mis;
    logic [31:0] exp_rpc;
    // execute replays the instruction decoded last cycle
    pc_e     = pc_pool[prev_sel];
    branch_e = prev_branch && !prev_flushed && !lookup_only;
    draw_bits(1, r);
    taken_e  = r[0];
    target_e = target_pool[prev_sel];
    draw_bits(4, r);
    sel = r[3:0];
    draw_bits(2, r);
    is_branch = lookup_only || (r[1:0] != 2'b00); // 3 in 4 are branches
    draw_bits(1, r);
    pc_d     = pc_pool[sel];
    opcode_d = is_branch ? `BP_OP_BRANCH : (r[0] ? 7'b0110011 : 7'b0010011);
    draw_bits(5, r);
    if (r[4:0] == 5'd0) begin
      draw_bits(30, r);
      target_pool[sel] = {r[29:0], 2'b00}; // branch target moves
    end
    #(CLK_PERIOD / 4);
    exp_taken = model_taken(pc_d, opcode_d);
    exp_pc    = model_pc(pc_d, opcode_d);
    exp_mis   = model_mispredict(branch_e, taken_e, target_e);
    exp_rpc   = (branch_e && taken_e) ? target_e : pc_e + 32'd4;
    if (lookup_only) begin
      compare_value("predict_taken after reset", 32'd0, 32'(predict_taken));
      compare_value("predict_pc after reset", pc_d + 32'd4, predict_pc);
    end
    compare_value("predict_taken", 32'(exp_taken), 32'(predict_taken));
    compare_value("predict_pc", exp_pc, predict_pc);
    compare_value("redirect", 32'(exp_mis), 32'(redirect));
    compare_value("flush_d", 32'(exp_mis), 32'(flush_d));
    compare_value("flush_e", 32'(exp_mis), 32'(flush_e));
    if (exp_mis) begin
      compare_value("redirect_pc", exp_rpc, redirect_pc);
    end
    model_clock(pc_d, opcode_d, pc_e, branch_e, taken_e, target_e, exp_mis);
    prev_sel     = sel;
    prev_branch  = is_branch;
    prev_flushed = exp_mis; // squashed slot resolves as no branch
  endtask

  initial begin
    rst_n        = 1'b0;
    pc_d         = 32'd0;
    opcode_d     = 7'd0;
    pc_e         = 32'd0;
    branch_e     = 1'b0;
    taken_e      = 1'b0;
    target_e     = 32'd0;
    lfsr_state   = 32'h5ea219c9;
    prev_sel     = 4'd0;
    prev_branch  = 1'b0;
    prev_flushed = 1'b0;
    test_name    = "reset";
    model_reset();
    build_pools();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    test_name = "reset_lookup";
    repeat (LOOKUP_CYCLES) begin
      run_cycle(1'b1);
      @(negedge clk);
    end
    test_name = "random_run";
    repeat (RUN_CYCLES) begin
      run_cycle(1'b0);
      @(negedge clk);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: src.f
+incdir+include
+incdir+sim
verilog/bp_pkg.sv
verilog/bp_table.sv
verilog/bp_decode.sv
verilog/bp_execute.sv
verilog/bp_result.sv
verilog/branch_predictor_top.sv
sim/tb_branch_predictor.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then scan the log
verilator --binary --timing --assert -f src.f --top-module tb_branch_predictor \
  -Mdir obj_dir > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_branch_predictor > sim.log 2>&1
grep -q "Finished with errors" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
